// File: Bender.yml
package:
  name: video_gen

sources:
  - src/video_gen_pkg.sv
  - src/video_timing.sv
  - src/video_regs.sv
  - src/video_bitmap.sv
  - src/video_gen.sv
  - target: test
    files:
      - test/video_gen_tb.sv
      - test/video_gen_assert.sv

// File: src/video_bitmap.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bitmap playfield, 8 bits per pixel
// fetches vram words and shifts out palette indices
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module video_bitmap #(
    parameter int H_VISIBLE = 32,
    parameter int H_FRONT   = 2,
    parameter int H_SYNC    = 4,
    parameter int H_BACK    = 4
) (
    input  logic                       clk,
    input  logic                       reset_i,
    input  video_gen_pkg::vid_timing_t timing_i,
    input  video_gen_pkg::pf_cfg_t     cfg_i,
    output logic                       vram_sel_o,
    output video_gen_pkg::addr_t       vram_addr_o,
    input  video_gen_pkg::word_t       vram_data_i,
    output video_gen_pkg::color_t      color_index_o
);

    localparam int H_OFF      = H_FRONT + H_SYNC + H_BACK;
    localparam int H_TOTAL    = H_OFF + H_VISIBLE;
    localparam int FETCH_LEAD = 3;      // issue, data, load, then first pixel

    // h_count of the first and last vram read on a line
    localparam video_gen_pkg::hres_t FETCH_FIRST = video_gen_pkg::hres_t'(H_OFF - FETCH_LEAD);
    localparam video_gen_pkg::hres_t FETCH_LAST  =
        video_gen_pkg::hres_t'(H_OFF - FETCH_LEAD + H_VISIBLE - 2);
    localparam video_gen_pkg::hres_t DE_FIRST = video_gen_pkg::hres_t'(H_OFF - 1);
    localparam video_gen_pkg::hres_t DE_LAST  = video_gen_pkg::hres_t'(H_TOTAL - 2);

    video_gen_pkg::hres_t  h_next;      // position of the following cycle
    video_gen_pkg::hres_t  px_x;        // pixel x of the following cycle
    video_gen_pkg::addr_t  line_addr;   // first word of current line
    video_gen_pkg::addr_t  fetch_addr;  // next word to read
    video_gen_pkg::word_t  pix_word;    // high byte is the current pixel
    video_gen_pkg::color_t pix_pre;
    logic                  issue_next;
    logic                  de_next;
    logic                  in_border;
    logic                  vram_rd_q;   // data is on vram_data_i this cycle

    always_comb begin
        h_next = timing_i.h_count + 1'b1;
        px_x   = timing_i.h_count - DE_FIRST;

        // one read every second cycle inside the window
        issue_next = timing_i.v_visible && !cfg_i.blank &&
                     (h_next >= FETCH_FIRST) && (h_next <= FETCH_LAST) &&
                     (h_next[0] == FETCH_FIRST[0]);

        de_next   = timing_i.v_visible &&
                    (timing_i.h_count >= DE_FIRST) && (timing_i.h_count <= DE_LAST);
        in_border = cfg_i.blank || (px_x < cfg_i.vid_left) || (px_x >= cfg_i.vid_right);

        // border pre-XORed so the colorbase XOR below cancels out
        pix_pre = in_border ? (cfg_i.border_color ^ cfg_i.colorbase) : pix_word[15:8];
    end

    // fetch addressing
    always_ff @(posedge clk) begin
        if (reset_i) begin
            vram_sel_o <= 1'b0;
            vram_rd_q  <= 1'b0;
            line_addr  <= '0;
            fetch_addr <= '0;
        end else begin
            vram_sel_o <= issue_next;
            vram_rd_q  <= vram_sel_o;

            if (timing_i.end_of_frame) begin
                line_addr  <= cfg_i.start_addr;
                fetch_addr <= cfg_i.start_addr;
            end else if (timing_i.end_of_line) begin
                if (timing_i.v_visible) begin
                    line_addr  <= line_addr + cfg_i.line_len;
                    fetch_addr <= line_addr + cfg_i.line_len;
                end else begin
                    fetch_addr <= line_addr;
                end
            end else if (issue_next) begin
                fetch_addr <= fetch_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_next) begin
            vram_addr_o <= fetch_addr;
        end
        // load on data cycles, otherwise move low byte up
        if (vram_rd_q) begin
            pix_word <= vram_data_i;
        end else begin
            pix_word <= {pix_word[7:0], 8'h00};
        end
    end

    // pixel out, same edge as dv_de
    always_ff @(posedge clk) begin
        if (reset_i) begin
            color_index_o <= '0;
        end else begin
            color_index_o <= de_next ? (pix_pre ^ cfg_i.colorbase) : '0;
        end
    end

endmodule

// File: src/video_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// video generator top level
// timing, config registers and bitmap playfield
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module video_gen #(
    parameter int H_VISIBLE = 32,
    parameter int H_FRONT   = 2,
    parameter int H_SYNC    = 4,
    parameter int H_BACK    = 4,
    parameter int V_VISIBLE = 8,
    parameter int V_FRONT   = 1,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 2
) (
    input  logic                    clk,
    input  logic                    reset_i,
    // config registers
    input  logic                    reg_wr_i,
    input  video_gen_pkg::reg_num_t reg_num_i,
    input  video_gen_pkg::word_t    reg_data_i,
    output video_gen_pkg::word_t    reg_data_o,
    output logic                    video_intr_o,
    // vram read port
    output logic                    vram_sel_o,
    output video_gen_pkg::addr_t    vram_addr_o,
    input  video_gen_pkg::word_t    vram_data_i,
    // video out
    output logic                    h_blank_o,
    output logic                    v_blank_o,
    output logic                    hsync_o,
    output logic                    vsync_o,
    output logic                    dv_de_o,
    output video_gen_pkg::color_t   color_index_o
);

    video_gen_pkg::vid_timing_t timing;
    video_gen_pkg::pf_cfg_t     pf_cfg;

    assign h_blank_o = ~timing.h_visible;
    assign v_blank_o = ~timing.v_visible;
    assign hsync_o   = timing.hsync;
    assign vsync_o   = timing.vsync;
    assign dv_de_o   = timing.dv_de;

    video_timing #(
        .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) i_video_timing (
        .clk     (clk),
        .reset_i (reset_i),
        .timing_o(timing)
    );

    video_regs #(
        .H_VISIBLE(H_VISIBLE),
        .V_VISIBLE(V_VISIBLE)
    ) i_video_regs (
        .clk         (clk),
        .reset_i     (reset_i),
        .reg_wr_i    (reg_wr_i),
        .reg_num_i   (reg_num_i),
        .reg_data_i  (reg_data_i),
        .timing_i    (timing),
        .reg_data_o  (reg_data_o),
        .video_intr_o(video_intr_o),
        .pf_cfg_o    (pf_cfg)
    );

    video_bitmap #(
        .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK)
    ) i_video_bitmap (
        .clk          (clk),
        .reset_i      (reset_i),
        .timing_i     (timing),
        .cfg_i        (pf_cfg),
        .vram_sel_o   (vram_sel_o),
        .vram_addr_o  (vram_addr_o),
        .vram_data_i  (vram_data_i),
        .color_index_o(color_index_o)
    );

endmodule

// File: src/video_gen_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// video generator shared types
// widths, register numbers, timing and playfield bundles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package video_gen_pkg;

    typedef logic [15:0] word_t;        // register and vram data word
    typedef logic [15:0] addr_t;        // vram word address
    typedef logic [7:0]  color_t;       // palette index
    typedef logic [10:0] hres_t;        // horizontal counter
    typedef logic [10:0] vres_t;        // vertical counter
    typedef logic [4:0]  reg_num_t;     // config register number

    // video config registers
    localparam reg_num_t XR_VID_CTRL     = 5'h00;  // border color
    localparam reg_num_t XR_VID_INTR     = 5'h03;  // write fires interrupt
    localparam reg_num_t XR_VID_LEFT     = 5'h04;
    localparam reg_num_t XR_VID_RIGHT    = 5'h05;
    localparam reg_num_t XR_SCANLINE     = 5'h08;  // read only
    localparam reg_num_t XR_VID_HSIZE    = 5'h0A;  // read only
    localparam reg_num_t XR_VID_VSIZE    = 5'h0B;  // read only

    // playfield registers
    localparam reg_num_t XR_PA_GFX_CTRL  = 5'h10;  // colorbase[15:8], blank[7]
    localparam reg_num_t XR_PA_DISP_ADDR = 5'h12;
    localparam reg_num_t XR_PA_LINE_LEN  = 5'h13;

    localparam color_t BORDER_RESET = 8'h08;       // dark grey, visible after reset

    // outputs of the timing generator, all registered
    typedef struct packed {
        hres_t h_count;
        vres_t v_count;
        logic  h_visible;
        logic  v_visible;
        logic  end_of_line;     // last cycle of a line
        logic  end_of_frame;    // last cycle of a frame
        logic  end_of_visible;  // last visible pixel
        logic  hsync;
        logic  vsync;
        logic  dv_de;           // display enable
    } vid_timing_t;

    // playfield configuration from the register block
    typedef struct packed {
        logic   blank;
        color_t colorbase;
        color_t border_color;
        hres_t  vid_left;       // first pixel inside window
        hres_t  vid_right;      // first pixel past window
        addr_t  start_addr;     // first line of frame
        word_t  line_len;       // words added per line
    } pf_cfg_t;

endpackage

// File: src/video_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// video config registers
// strobe writes, registered readback, video interrupt
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module video_regs #(
    parameter int H_VISIBLE = 32,
    parameter int V_VISIBLE = 8
) (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       reg_wr_i,
    input  video_gen_pkg::reg_num_t    reg_num_i,
    input  video_gen_pkg::word_t       reg_data_i,
    input  video_gen_pkg::vid_timing_t timing_i,
    output video_gen_pkg::word_t       reg_data_o,
    output logic                       video_intr_o,
    output video_gen_pkg::pf_cfg_t     pf_cfg_o
);

    video_gen_pkg::word_t rd_data;

    // register writes
    always_ff @(posedge clk) begin
        if (reset_i) begin
            video_intr_o          <= 1'b0;
            pf_cfg_o.border_color <= video_gen_pkg::BORDER_RESET;
            pf_cfg_o.vid_left     <= '0;
            pf_cfg_o.vid_right    <= video_gen_pkg::hres_t'(H_VISIBLE);
            pf_cfg_o.blank        <= 1'b1;          // playfield off until enabled
            pf_cfg_o.colorbase    <= '0;
            pf_cfg_o.start_addr   <= '0;
            pf_cfg_o.line_len     <= video_gen_pkg::word_t'(H_VISIBLE / 2);
        end else begin
            video_intr_o <= timing_i.end_of_visible;

            if (reg_wr_i) begin
                case (reg_num_i)
                    video_gen_pkg::XR_VID_CTRL: begin
                        pf_cfg_o.border_color <= reg_data_i[7:0];
                    end
                    video_gen_pkg::XR_VID_INTR: begin
                        video_intr_o <= 1'b1;       // software interrupt
                    end
                    video_gen_pkg::XR_VID_LEFT: begin
                        pf_cfg_o.vid_left <= video_gen_pkg::hres_t'(reg_data_i);
                    end
                    video_gen_pkg::XR_VID_RIGHT: begin
                        pf_cfg_o.vid_right <= video_gen_pkg::hres_t'(reg_data_i);
                    end
                    video_gen_pkg::XR_PA_GFX_CTRL: begin
                        pf_cfg_o.colorbase <= reg_data_i[15:8];
                        pf_cfg_o.blank     <= reg_data_i[7];
                    end
                    video_gen_pkg::XR_PA_DISP_ADDR: begin
                        pf_cfg_o.start_addr <= reg_data_i;
                    end
                    video_gen_pkg::XR_PA_LINE_LEN: begin
                        pf_cfg_o.line_len <= reg_data_i;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // readback mux
    always_comb begin
        case (reg_num_i)
            video_gen_pkg::XR_VID_CTRL: begin
                rd_data = {8'h00, pf_cfg_o.border_color};
            end
            video_gen_pkg::XR_VID_LEFT: begin
                rd_data = video_gen_pkg::word_t'(pf_cfg_o.vid_left);
            end
            video_gen_pkg::XR_VID_RIGHT: begin
                rd_data = video_gen_pkg::word_t'(pf_cfg_o.vid_right);
            end
            video_gen_pkg::XR_SCANLINE: begin
                rd_data = video_gen_pkg::word_t'(timing_i.v_count);
            end
            video_gen_pkg::XR_VID_HSIZE: begin
                rd_data = video_gen_pkg::word_t'(H_VISIBLE);
            end
            video_gen_pkg::XR_VID_VSIZE: begin
                rd_data = video_gen_pkg::word_t'(V_VISIBLE);
            end
            video_gen_pkg::XR_PA_GFX_CTRL: begin
                rd_data = {pf_cfg_o.colorbase, pf_cfg_o.blank, 7'b0};
            end
            video_gen_pkg::XR_PA_DISP_ADDR: begin
                rd_data = pf_cfg_o.start_addr;
            end
            video_gen_pkg::XR_PA_LINE_LEN: begin
                rd_data = pf_cfg_o.line_len;
            end
            default: begin
                rd_data = '0;                       // VID_INTR and unused numbers
            end
        endcase
    end

    // read data one cycle after the number
    always_ff @(posedge clk) begin
        reg_data_o <= rd_data;
    end

endmodule

// File: src/video_timing.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// video timing generator
// h/v counters with registered sync and visibility
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module video_timing #(
    parameter int H_VISIBLE = 32,
    parameter int H_FRONT   = 2,
    parameter int H_SYNC    = 4,
    parameter int H_BACK    = 4,
    parameter int V_VISIBLE = 8,
    parameter int V_FRONT   = 1,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 2
) (
    input  logic                      clk,
    input  logic                      reset_i,
    output video_gen_pkg::vid_timing_t timing_o
);

    // offscreen part comes first in each line and frame
    localparam int H_OFF   = H_FRONT + H_SYNC + H_BACK;
    localparam int H_TOTAL = H_OFF + H_VISIBLE;
    localparam int V_OFF   = V_FRONT + V_SYNC + V_BACK;
    localparam int V_TOTAL = V_OFF + V_VISIBLE;

    localparam video_gen_pkg::hres_t H_LAST = video_gen_pkg::hres_t'(H_TOTAL - 1);
    localparam video_gen_pkg::vres_t V_LAST = video_gen_pkg::vres_t'(V_TOTAL - 1);

    video_gen_pkg::hres_t h_next;
    video_gen_pkg::vres_t v_next;
    logic                 h_wrap;
    logic                 v_wrap;
    logic                 h_vis_next;
    logic                 v_vis_next;
    logic                 hs_next;
    logic                 vs_next;
    logic                 eol_next;

    // next counter values, flags are registered from these
    always_comb begin
        h_wrap = (timing_o.h_count == H_LAST);
        v_wrap = (timing_o.v_count == V_LAST);
        h_next = h_wrap ? '0 : timing_o.h_count + 1'b1;
        v_next = timing_o.v_count;
        if (h_wrap) begin
            v_next = v_wrap ? '0 : timing_o.v_count + 1'b1;
        end

        h_vis_next = (h_next >= video_gen_pkg::hres_t'(H_OFF));
        v_vis_next = (v_next >= video_gen_pkg::vres_t'(V_OFF));
        hs_next    = (h_next >= video_gen_pkg::hres_t'(H_FRONT)) &&
                     (h_next <  video_gen_pkg::hres_t'(H_FRONT + H_SYNC));
        vs_next    = (v_next >= video_gen_pkg::vres_t'(V_FRONT)) &&
                     (v_next <  video_gen_pkg::vres_t'(V_FRONT + V_SYNC));
        eol_next   = (h_next == H_LAST);
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            timing_o <= '0;
        end else begin
            timing_o.h_count      <= h_next;
            timing_o.v_count      <= v_next;
            timing_o.h_visible    <= h_vis_next;
            timing_o.v_visible    <= v_vis_next;
            timing_o.hsync        <= hs_next;
            timing_o.vsync        <= vs_next;
            timing_o.dv_de        <= h_vis_next & v_vis_next;
            timing_o.end_of_line  <= eol_next;
            timing_o.end_of_frame <= eol_next && (v_next == V_LAST);
            // visible lines are last, so this lands on the frame's final pixel
            timing_o.end_of_visible <= eol_next && v_vis_next && (v_next == V_LAST);
        end
    end

endmodule

// File: test/video_gen_assert.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// timing and interrupt properties, bound into the register block
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module video_gen_assert (
    input logic                       clk,
    input logic                       reset_i,
    input video_gen_pkg::vid_timing_t timing_i,
    input logic                       intr_i
);

    int fail_cnt = 0;   // failed properties so far

    // interrupt is a single cycle pulse
    intr_pulse: assert property (@(posedge clk) disable iff (reset_i)
        intr_i |=> !intr_i)
        else begin
            fail_cnt++;
            $error("video interrupt held high for two cycles");
        end

    hsync_offscreen: assert property (@(posedge clk) disable iff (reset_i)
        $rose(timing_i.hsync) |-> !timing_i.h_visible)
        else begin
            fail_cnt++;
            $error("hsync rose inside the visible area");
        end

    de_match: assert property (@(posedge clk) disable iff (reset_i)
        timing_i.dv_de == (timing_i.h_visible && timing_i.v_visible))
        else begin
            fail_cnt++;
            $error("display enable differs from visibility");
        end

endmodule

bind video_regs video_gen_assert i_video_gen_assert (
    .clk     (clk),
    .reset_i (reset_i),
    .timing_i(timing_i),
    .intr_i  (video_intr_o)
);

// File: test/video_gen_stim.txt
// op reg data expected, all hex
// op 0 write, 1 read, 2 pixel frame, 3 random window, 4 timing, 5 scanline, 6 intr, F end
1 00 0000 0008
1 05 0000 0020
1 10 0000 0080
1 13 0000 0010
1 0A 0000 0020
1 0B 0000 0008
1 04 0000 0000
1 12 0000 0000
2 00 0000 0000
0 00 0033 0000
1 00 0000 0033
0 04 0003 0000
1 04 0000 0003
0 05 001C 0000
1 05 0000 001C
0 12 0100 0000
1 12 0000 0100
0 13 0014 0000
1 13 0000 0014
0 10 5A00 0000
1 10 0000 5A00
1 07 0000 0000
1 1F 0000 0000
1 03 0000 0000
4 00 0000 0000
5 00 0000 0000
6 00 0000 0001
6 00 0001 0002
2 00 0000 0000
3 00 0000 0000
2 00 0000 0000
0 10 5A80 0000
2 00 0000 0000
0 10 C300 0000
3 00 0000 0000
2 00 0000 0000
F 00 0000 0000

// File: test/video_gen_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// video generator testbench
// file driven register ops, vram model, frame and pixel checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module video_gen_tb;

    localparam int H_VISIBLE = 32, H_FRONT = 2, H_SYNC = 4, H_BACK = 4;
    localparam int V_VISIBLE = 8, V_FRONT = 1, V_SYNC = 2, V_BACK = 2;
    localparam int H_TOTAL = H_FRONT + H_SYNC + H_BACK + H_VISIBLE;
    localparam int V_TOTAL = V_FRONT + V_SYNC + V_BACK + V_VISIBLE;
    localparam int MAX_OPS = 64;
    // no op spans more than four frames
    localparam int TIMEOUT = (MAX_OPS * 4 + 4) * H_TOTAL * V_TOTAL * 10;

    logic clk = 1'b0;
    logic reset_i, reg_wr_i, video_intr_o, vram_sel_o;
    logic h_blank_o, v_blank_o, hsync_o, vsync_o, dv_de_o;
    video_gen_pkg::reg_num_t reg_num_i;
    video_gen_pkg::word_t    reg_data_i, reg_data_o, vram_data_i;
    video_gen_pkg::addr_t    vram_addr_o;
    video_gen_pkg::color_t   color_index_o;

    logic [15:0] stim_mem [0:MAX_OPS*4-1];
    int seed = 37721;

    // expected config shadowed from the writes
    video_gen_pkg::color_t sh_border, sh_cb;
    video_gen_pkg::addr_t  sh_start;
    video_gen_pkg::word_t  sh_len;
    logic                  sh_blank;
    int                    sh_left, sh_right;

    logic mon_en = 1'b0, pix_en = 1'b0;
    logic dv_de_q, vsync_q, h_blank_q;
    int   px, py, line_cnt, intr_cnt;

    video_gen #(
        .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) i_video_gen (.*);

    always #5 clk = ~clk;

    task automatic fail_now();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input video_gen_pkg::word_t got, exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_color(input string name, input video_gen_pkg::color_t got, exp);
        if (got !== exp) begin
            $display("[ERROR] %s at x %0d y %0d: got 0x%h, expected 0x%h",
                     name, px, py, got, exp);
            fail_now();
        end
    endtask

    task automatic check_bit(input string name, input logic got, exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            fail_now();
        end
    endtask

    // vram model answers one clock after the read with address ^ a5c3
    always @(posedge clk) begin
        logic                 sel;
        video_gen_pkg::addr_t addr;
        sel  = vram_sel_o;
        addr = vram_addr_o;
        #1 vram_data_i = sel ? (addr ^ 16'hA5C3) : 16'h0000;
    end

    function automatic video_gen_pkg::color_t expected_pixel(input int x, input int y);
        video_gen_pkg::addr_t a;
        video_gen_pkg::word_t w;
        a = sh_start + video_gen_pkg::addr_t'(y) * sh_len + video_gen_pkg::addr_t'(x / 2);
        w = a ^ 16'hA5C3;
        if (sh_blank || x < sh_left || x >= sh_right) begin
            return sh_border;
        end
        return (x % 2 == 1) ? (w[7:0] ^ sh_cb) : (w[15:8] ^ sh_cb);
    endfunction

    // output monitor sampled mid cycle
    always @(negedge clk) begin
        if (i_video_gen.i_video_regs.i_video_gen_assert.fail_cnt != 0) begin
            $display("a bound timing or interrupt assertion failed");
            fail_now();
        end
        if (mon_en) begin
            if (dv_de_o) begin
                if (pix_en) check_color("color_index_o", color_index_o, expected_pixel(px, py));
                px++;
            end else begin
                check_color("color_index_o blanked", color_index_o, 8'h00);
                if (dv_de_q) begin
                    // interrupt follows the last visible pixel
                    if (py == V_VISIBLE - 1) check_bit("video_intr_o", video_intr_o, 1'b1);
                    py++;
                    px = 0;
                end
            end
            if (vsync_o) begin
                py = 0;
                px = 0;
            end
            if (vsync_o && !vsync_q) line_cnt = V_FRONT;     // vsync starts on this line
            else if (h_blank_o && !h_blank_q) line_cnt = (line_cnt + 1) % V_TOTAL;
            if (video_intr_o) intr_cnt++;
        end
        dv_de_q   = dv_de_o;
        vsync_q   = vsync_o;
        h_blank_q = h_blank_o;
    end

    task automatic write_reg(input video_gen_pkg::reg_num_t num, input video_gen_pkg::word_t data);
        @(posedge clk);
        #1;
        reg_wr_i   = 1'b1;
        reg_num_i  = num;
        reg_data_i = data;
        @(posedge clk);
        #1 reg_wr_i = 1'b0;
        case (num)
            video_gen_pkg::XR_VID_CTRL:     sh_border = data[7:0];
            video_gen_pkg::XR_VID_LEFT:     sh_left   = data[10:0];
            video_gen_pkg::XR_VID_RIGHT:    sh_right  = data[10:0];
            video_gen_pkg::XR_PA_DISP_ADDR: sh_start  = data;
            video_gen_pkg::XR_PA_LINE_LEN:  sh_len    = data;
            video_gen_pkg::XR_PA_GFX_CTRL: begin
                sh_cb    = data[15:8];
                sh_blank = data[7];
            end
            default: ;
        endcase
    endtask

    // returns readback plus the scanline seen while the number was presented
    task automatic read_reg(input video_gen_pkg::reg_num_t num, output video_gen_pkg::word_t val,
                            output int line_snap);
        @(posedge clk);
        #1 reg_num_i = num;
        @(negedge clk);
        #1 line_snap = line_cnt;
        @(negedge clk);
        val = reg_data_o;
    endtask

    task automatic check_frame_timing();
        int   cnt, width, lines;
        logic prev, prev_vs, done;
        @(posedge hsync_o);
        @(negedge clk);
        cnt   = 1;
        width = 1;
        prev  = 1'b1;
        done  = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (hsync_o && !prev) begin
                done = 1'b1;
            end else begin
                cnt++;
                if (hsync_o) width++;
            end
            prev = hsync_o;
        end
        check_word("hsync period", video_gen_pkg::word_t'(cnt), video_gen_pkg::word_t'(H_TOTAL));
        check_word("hsync width", video_gen_pkg::word_t'(width), video_gen_pkg::word_t'(H_SYNC));
        @(posedge vsync_o);
        lines   = 0;
        prev    = h_blank_o;
        prev_vs = 1'b1;
        done    = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (vsync_o && !prev_vs) begin
                done = 1'b1;                                // next frame begins
            end else if (!h_blank_o && prev && !v_blank_o) begin
                lines++;                                    // visible part of a line begins
            end
            prev    = h_blank_o;
            prev_vs = vsync_o;
        end
        check_word("visible lines", video_gen_pkg::word_t'(lines),
                   video_gen_pkg::word_t'(V_VISIBLE));
    endtask

    task automatic check_intr(input logic sw_write, input video_gen_pkg::word_t exp);
        int start;
        @(posedge vsync_o);
        start = intr_cnt;
        if (sw_write) write_reg(video_gen_pkg::XR_VID_INTR, 16'h0000);
        @(posedge vsync_o);
        check_word("video_intr_o pulses", video_gen_pkg::word_t'(intr_cnt - start), exp);
    endtask

    task automatic check_pixel_frame();
        repeat (2) @(posedge vsync_o);      // new start address is latched by now
        pix_en = 1'b1;
        @(posedge vsync_o);
        pix_en = 1'b0;
    endtask

    initial begin
        #(TIMEOUT);
        $display("timeout: the register and frame tests did not finish in time");
        $display("tests failed");
        $fatal(1);
    end

    initial begin
        logic [15:0]          op, num, data, exp;
        video_gen_pkg::word_t rd;
        int                   snap, r, i;
        logic                 done;
        reset_i    = 1'b1;
        reg_wr_i   = 1'b0;
        reg_num_i  = '0;
        reg_data_i = '0;
        vram_data_i = '0;
        sh_border = video_gen_pkg::BORDER_RESET;
        sh_cb     = '0;
        sh_blank  = 1'b1;
        sh_left   = 0;
        sh_right  = H_VISIBLE;
        sh_start  = '0;
        sh_len    = H_VISIBLE / 2;
        px = 0;
        py = 0;
        line_cnt = 0;
        intr_cnt = 0;
        $readmemh("test/video_gen_stim.txt", stim_mem);

        repeat (2) @(posedge clk);
        @(negedge clk);
        check_bit("video_intr_o", video_intr_o, 1'b0);
        check_bit("hsync_o", hsync_o, 1'b0);
        check_bit("vsync_o", vsync_o, 1'b0);
        check_bit("dv_de_o", dv_de_o, 1'b0);
        check_bit("vram_sel_o", vram_sel_o, 1'b0);
        @(posedge clk);
        #1 reset_i = 1'b0;
        mon_en = 1'b1;

        done = 1'b0;
        for (i = 0; i < MAX_OPS && !done; i++) begin
            op   = stim_mem[4*i];
            num  = stim_mem[4*i+1];
            data = stim_mem[4*i+2];
            exp  = stim_mem[4*i+3];
            case (op)
                16'h0: write_reg(num[4:0], data);
                16'h1: begin
                    read_reg(num[4:0], rd, snap);
                    check_word("reg_data_o", rd, exp);
                end
                16'h2: check_pixel_frame();
                16'h3: begin
                    r = $random(seed);
                    write_reg(video_gen_pkg::XR_VID_LEFT, {12'h000, r[3:0]});
                    write_reg(video_gen_pkg::XR_VID_RIGHT, 16'd16 + r[8:4]);
                end
                16'h4: check_frame_timing();
                16'h5: begin
                    read_reg(video_gen_pkg::XR_SCANLINE, rd, snap);
                    check_word("reg_data_o scanline", rd, video_gen_pkg::word_t'(snap));
                end
                16'h6: check_intr(data[0], exp);
                16'hF: done = 1'b1;
                default: begin
                    $display("stim file has an unknown op code or no end marker at op %0d", i);
                    fail_now();
                end
            endcase
        end
        if (i_video_gen.i_video_regs.i_video_gen_assert.fail_cnt != 0) begin
            $display("a bound timing or interrupt assertion failed");
            fail_now();
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

// File: verilog.f
src/video_gen_pkg.sv
src/video_timing.sv
src/video_regs.sv
src/video_bitmap.sv
src/video_gen.sv
test/video_gen_tb.sv
test/video_gen_assert.sv
